/* axil_pkg.sv */
// AXI4-Lite channel and bundle types, imported by every crossbar module and the testbench
package axil_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [2:0]           prot; // Passed along untouched
  } aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [2:0]           prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    resp_e                resp;
  } r_chan_t;

  // Manager to subordinate direction
  typedef struct packed {
    logic     aw_valid;
    aw_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
    logic     ar_valid;
    ar_chan_t ar;
    logic     r_ready;
  } axil_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
  } axil_resp_t;

endpackage

/* xbar_pkg.sv */
// Address map rule and select helpers used by the decoder, the demux and the crossbar top
package xbar_pkg;
  import axil_pkg::*;

  localparam int unsigned IdxWidth = 8;

  typedef logic [IdxWidth-1:0] idx_t;

  // One window of the address map, end_addr is exclusive
  typedef struct packed {
    idx_t                 idx;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
  } addr_rule_t;

  // Select value that steers a transaction to the decode-error responder
  function automatic idx_t err_select(input int unsigned num_sub);
    return idx_t'(num_sub);
  endfunction

  // Bits needed to count from 0 up to and including max_cnt
  function automatic int unsigned cnt_width(input int unsigned max_cnt);
    return (max_cnt > 0) ? $clog2(max_cnt + 1) : 1;
  endfunction

endpackage

/* axil_addr_decode.sv */
// Combinational address map lookup, one instance per AW and AR channel of each manager port
`timescale 1ns/1ps

module axil_addr_decode import axil_pkg::*, xbar_pkg::*; #(
  parameter int unsigned NumSub   = 3,
  parameter int unsigned NumRules = 3
) (
  input  logic       [AddrWidth-1:0] addr_i,
  input  addr_rule_t [NumRules-1:0]  addr_map_i,
  output logic       [IdxWidth-1:0]  idx_o,
  output logic                       dec_error_o
);

  logic matched;

  always_comb begin
    matched = 1'b0;
    idx_o   = '0;
    // Later rules override earlier ones
    for (int unsigned r = 0; r < NumRules; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        matched = 1'b1;
        idx_o   = addr_map_i[r].idx;
      end
    end
    // A rule pointing past the last subordinate counts as a miss
    dec_error_o = !matched || (idx_o >= NumSub);
  end

endmodule

/* axil_demux.sv */
// Manager-side router, steers AW/W/AR of one manager port to a subordinate or the error responder
`timescale 1ns/1ps

module axil_demux import axil_pkg::*, xbar_pkg::*; #(
  parameter int unsigned NumSub   = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  axil_req_t                  req_i,
  input  logic       [IdxWidth-1:0]  aw_select_i, // NumSub selects the error responder
  input  logic       [IdxWidth-1:0]  ar_select_i,
  output axil_resp_t                 resp_o,
  output axil_req_t  [NumSub:0]      reqs_o,
  input  axil_resp_t [NumSub:0]      resps_i
);

  localparam int unsigned CntW = cnt_width(MaxTrans);
  localparam int unsigned PtrW = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;

  logic [CntW-1:0] w_cnt_q, r_cnt_q;    // Outstanding writes and reads
  idx_t            aw_sel_q, ar_sel_q;  // Target of the outstanding ones
  idx_t            wsel_mem [MaxTrans];
  logic [PtrW-1:0] wsel_wr_q, wsel_rd_q;
  logic [CntW-1:0] wsel_cnt_q;
  idx_t            w_sel;
  logic            aw_ok, ar_ok, w_route;
  logic            aw_fire, w_fire, b_fire, ar_fire, r_fire;

  always_comb begin
    w_sel   = wsel_mem[wsel_rd_q];
    w_route = (wsel_cnt_q != '0);
    // Only one target at a time, so responses cannot come back out of order
    aw_ok = (w_cnt_q != CntW'(MaxTrans)) && ((w_cnt_q == '0) || (aw_select_i == aw_sel_q));
    ar_ok = (r_cnt_q != CntW'(MaxTrans)) && ((r_cnt_q == '0) || (ar_select_i == ar_sel_q));

    resp_o = '0;
    for (int unsigned j = 0; j <= NumSub; j++) begin
      reqs_o[j]          = '0;
      reqs_o[j].aw       = req_i.aw;
      reqs_o[j].w        = req_i.w;
      reqs_o[j].ar       = req_i.ar;
      reqs_o[j].aw_valid = req_i.aw_valid && aw_ok && (aw_select_i == j);
      reqs_o[j].w_valid  = req_i.w_valid && w_route && (w_sel == j);
      reqs_o[j].b_ready  = req_i.b_ready && (w_cnt_q != '0) && (aw_sel_q == j);
      reqs_o[j].ar_valid = req_i.ar_valid && ar_ok && (ar_select_i == j);
      reqs_o[j].r_ready  = req_i.r_ready && (r_cnt_q != '0) && (ar_sel_q == j);

      if (aw_select_i == j) resp_o.aw_ready = aw_ok && resps_i[j].aw_ready;
      if (w_sel == j)       resp_o.w_ready  = w_route && resps_i[j].w_ready;
      if (ar_select_i == j) resp_o.ar_ready = ar_ok && resps_i[j].ar_ready;
      if (aw_sel_q == j) begin
        resp_o.b_valid = (w_cnt_q != '0) && resps_i[j].b_valid;
        resp_o.b       = resps_i[j].b;
      end
      if (ar_sel_q == j) begin
        resp_o.r_valid = (r_cnt_q != '0) && resps_i[j].r_valid;
        resp_o.r       = resps_i[j].r;
      end
    end

    aw_fire = req_i.aw_valid && resp_o.aw_ready;
    w_fire  = req_i.w_valid && resp_o.w_ready;
    b_fire  = resp_o.b_valid && req_i.b_ready;
    ar_fire = req_i.ar_valid && resp_o.ar_ready;
    r_fire  = resp_o.r_valid && req_i.r_ready;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_cnt_q    <= '0;
      r_cnt_q    <= '0;
      aw_sel_q   <= '0;
      ar_sel_q   <= '0;
      wsel_wr_q  <= '0;
      wsel_rd_q  <= '0;
      wsel_cnt_q <= '0;
    end else begin
      if (aw_fire && !b_fire) begin
        w_cnt_q <= w_cnt_q + 1'b1;
      end else if (b_fire && !aw_fire) begin
        w_cnt_q <= w_cnt_q - 1'b1;
      end
      if (ar_fire && !r_fire) begin
        r_cnt_q <= r_cnt_q + 1'b1;
      end else if (r_fire && !ar_fire) begin
        r_cnt_q <= r_cnt_q - 1'b1;
      end

      if (aw_fire) begin
        aw_sel_q  <= aw_select_i;
        wsel_wr_q <= (wsel_wr_q == PtrW'(MaxTrans - 1)) ? '0 : wsel_wr_q + 1'b1;
      end
      if (ar_fire) ar_sel_q <= ar_select_i;
      if (w_fire) begin
        wsel_rd_q <= (wsel_rd_q == PtrW'(MaxTrans - 1)) ? '0 : wsel_rd_q + 1'b1;
      end

      if (aw_fire && !w_fire) begin
        wsel_cnt_q <= wsel_cnt_q + 1'b1;
      end else if (w_fire && !aw_fire) begin
        wsel_cnt_q <= wsel_cnt_q - 1'b1;
      end
    end
  end

  // W order follows AW order
  always_ff @(posedge clk_i) begin
    if (aw_fire) wsel_mem[wsel_wr_q] <= aw_select_i;
  end

endmodule

/* axil_mux.sv */
// Subordinate-side round-robin arbiter, merges all manager ports onto one subordinate port
`timescale 1ns/1ps

module axil_mux import axil_pkg::*; #(
  parameter int unsigned NumMgr   = 2,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axil_req_t  [NumMgr-1:0] reqs_i,
  output axil_resp_t [NumMgr-1:0] resps_o,
  output axil_req_t               req_o,
  input  axil_resp_t              resp_i
);

  localparam int unsigned IdxW    = (NumMgr > 1) ? $clog2(NumMgr) : 1;
  localparam int unsigned PtrW    = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;
  localparam int unsigned CntW    = $clog2(MaxTrans + 1);
  localparam int unsigned NumFifo = 3;

  // Index FIFOs, W and B filled by AW grants, R by AR grants
  typedef enum logic [1:0] {
    FIFO_W = 2'd0,
    FIFO_B = 2'd1,
    FIFO_R = 2'd2
  } fifo_e;

  logic [IdxW-1:0]    fifo_mem [NumFifo][MaxTrans];
  logic [PtrW-1:0]    fifo_wr_q [NumFifo];
  logic [PtrW-1:0]    fifo_rd_q [NumFifo];
  logic [CntW-1:0]    fifo_cnt_q [NumFifo];
  logic [IdxW-1:0]    fifo_din [NumFifo];
  logic [NumFifo-1:0] fifo_push, fifo_pop, fifo_full, fifo_empty;

  logic [NumMgr-1:0] aw_vld, ar_vld;
  logic [IdxW:0]     aw_pick, ar_pick;       // Found flag on top of the index
  logic [IdxW-1:0]   aw_rr_q, ar_rr_q;
  logic              aw_lock_q, ar_lock_q;   // Grant held until transfer
  logic [IdxW-1:0]   aw_lock_idx_q, ar_lock_idx_q;
  logic [IdxW-1:0]   aw_idx, ar_idx, w_head, b_head, r_head;
  logic              aw_req, ar_req;
  logic              aw_fire, w_fire, b_fire, ar_fire, r_fire;

  // First requester at or after the pointer
  function automatic logic [IdxW:0] rr_pick(input logic [NumMgr-1:0] vld,
                                            input logic [IdxW-1:0]   ptr);
    logic [IdxW:0] res;
    logic          found;
    int unsigned   cand;
    res   = '0;
    found = 1'b0;
    for (int unsigned k = 0; k < NumMgr; k++) begin
      cand = (ptr + k) % NumMgr;
      if (!found && vld[cand]) begin
        found = 1'b1;
        res   = {1'b1, IdxW'(cand)};
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int f = 0; f < NumFifo; f++) begin
      fifo_full[f]  = (fifo_cnt_q[f] == CntW'(MaxTrans));
      fifo_empty[f] = (fifo_cnt_q[f] == '0);
    end
    for (int unsigned i = 0; i < NumMgr; i++) begin
      aw_vld[i] = reqs_i[i].aw_valid;
      ar_vld[i] = reqs_i[i].ar_valid;
    end
    aw_pick = rr_pick(aw_vld, aw_rr_q);
    ar_pick = rr_pick(ar_vld, ar_rr_q);
    aw_idx  = aw_lock_q ? aw_lock_idx_q : aw_pick[IdxW-1:0];
    ar_idx  = ar_lock_q ? ar_lock_idx_q : ar_pick[IdxW-1:0];
    aw_req  = (aw_lock_q || aw_pick[IdxW]) && !fifo_full[FIFO_W] && !fifo_full[FIFO_B];
    ar_req  = (ar_lock_q || ar_pick[IdxW]) && !fifo_full[FIFO_R];
    w_head  = fifo_mem[FIFO_W][fifo_rd_q[FIFO_W]];
    b_head  = fifo_mem[FIFO_B][fifo_rd_q[FIFO_B]];
    r_head  = fifo_mem[FIFO_R][fifo_rd_q[FIFO_R]];

    req_o          = '0;
    req_o.aw_valid = aw_req;
    req_o.aw       = reqs_i[aw_idx].aw;
    req_o.w_valid  = !fifo_empty[FIFO_W] && reqs_i[w_head].w_valid;
    req_o.w        = reqs_i[w_head].w;
    req_o.b_ready  = !fifo_empty[FIFO_B] && reqs_i[b_head].b_ready;
    req_o.ar_valid = ar_req;
    req_o.ar       = reqs_i[ar_idx].ar;
    req_o.r_ready  = !fifo_empty[FIFO_R] && reqs_i[r_head].r_ready;

    for (int unsigned i = 0; i < NumMgr; i++) begin
      resps_o[i]          = '0;
      resps_o[i].b        = resp_i.b;
      resps_o[i].r        = resp_i.r;
      resps_o[i].aw_ready = aw_req && (aw_idx == i) && resp_i.aw_ready;
      resps_o[i].w_ready  = !fifo_empty[FIFO_W] && (w_head == i) && resp_i.w_ready;
      resps_o[i].b_valid  = !fifo_empty[FIFO_B] && (b_head == i) && resp_i.b_valid;
      resps_o[i].ar_ready = ar_req && (ar_idx == i) && resp_i.ar_ready;
      resps_o[i].r_valid  = !fifo_empty[FIFO_R] && (r_head == i) && resp_i.r_valid;
    end

    aw_fire = aw_req && resp_i.aw_ready;
    w_fire  = req_o.w_valid && resp_i.w_ready;
    b_fire  = resp_i.b_valid && req_o.b_ready;
    ar_fire = ar_req && resp_i.ar_ready;
    r_fire  = resp_i.r_valid && req_o.r_ready;

    fifo_push = {ar_fire, aw_fire, aw_fire}; // Bit order follows fifo_e
    fifo_pop  = {r_fire, b_fire, w_fire};
    fifo_din[FIFO_W] = aw_idx;
    fifo_din[FIFO_B] = aw_idx;
    fifo_din[FIFO_R] = ar_idx;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_rr_q       <= '0;
      ar_rr_q       <= '0;
      aw_lock_q     <= 1'b0;
      ar_lock_q     <= 1'b0;
      aw_lock_idx_q <= '0;
      ar_lock_idx_q <= '0;
      for (int f = 0; f < NumFifo; f++) begin
        fifo_wr_q[f]  <= '0;
        fifo_rd_q[f]  <= '0;
        fifo_cnt_q[f] <= '0;
      end
    end else begin
      if (aw_fire) begin
        aw_rr_q   <= (aw_idx == IdxW'(NumMgr - 1)) ? '0 : aw_idx + 1'b1;
        aw_lock_q <= 1'b0;
      end else if (aw_req) begin
        aw_lock_q     <= 1'b1;
        aw_lock_idx_q <= aw_idx;
      end
      if (ar_fire) begin
        ar_rr_q   <= (ar_idx == IdxW'(NumMgr - 1)) ? '0 : ar_idx + 1'b1;
        ar_lock_q <= 1'b0;
      end else if (ar_req) begin
        ar_lock_q     <= 1'b1;
        ar_lock_idx_q <= ar_idx;
      end
      for (int f = 0; f < NumFifo; f++) begin
        if (fifo_push[f]) begin
          fifo_wr_q[f] <= (fifo_wr_q[f] == PtrW'(MaxTrans - 1)) ? '0 : fifo_wr_q[f] + 1'b1;
        end
        if (fifo_pop[f]) begin
          fifo_rd_q[f] <= (fifo_rd_q[f] == PtrW'(MaxTrans - 1)) ? '0 : fifo_rd_q[f] + 1'b1;
        end
        if (fifo_push[f] && !fifo_pop[f]) begin
          fifo_cnt_q[f] <= fifo_cnt_q[f] + 1'b1;
        end else if (fifo_pop[f] && !fifo_push[f]) begin
          fifo_cnt_q[f] <= fifo_cnt_q[f] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int f = 0; f < NumFifo; f++) begin
      if (fifo_push[f]) fifo_mem[f][fifo_wr_q[f]] <= fifo_din[f];
    end
  end

endmodule

/* axil_err_slv.sv */
// Decode-error responder behind each manager port, completes unmapped accesses with DECERR
`timescale 1ns/1ps

module axil_err_slv import axil_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  axil_req_t  req_i,
  output axil_resp_t resp_o
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_GOT_AW,
    WR_GOT_W,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q, rd_state_d;
  logic      aw_fire, w_fire;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = (wr_state_q == WR_IDLE) || (wr_state_q == WR_GOT_W);
    resp_o.w_ready  = (wr_state_q == WR_IDLE) || (wr_state_q == WR_GOT_AW);
    resp_o.b_valid  = (wr_state_q == WR_RESP);
    resp_o.b.resp   = DECERR;
    resp_o.ar_ready = (rd_state_q == RD_IDLE);
    resp_o.r_valid  = (rd_state_q == RD_RESP);
    resp_o.r.data   = '0;
    resp_o.r.resp   = DECERR;

    aw_fire = req_i.aw_valid && resp_o.aw_ready;
    w_fire  = req_i.w_valid && resp_o.w_ready;

    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE: begin
        if (aw_fire && w_fire) wr_state_d = WR_RESP;
        else if (aw_fire)      wr_state_d = WR_GOT_AW;
        else if (w_fire)       wr_state_d = WR_GOT_W;
      end
      WR_GOT_AW: if (w_fire) wr_state_d = WR_RESP;
      WR_GOT_W:  if (aw_fire) wr_state_d = WR_RESP;
      WR_RESP:   if (req_i.b_ready) wr_state_d = WR_IDLE;
      default:   wr_state_d = WR_IDLE;
    endcase

    rd_state_d = rd_state_q;
    if (rd_state_q == RD_IDLE && req_i.ar_valid) begin
      rd_state_d = RD_RESP;
    end else if (rd_state_q == RD_RESP && req_i.r_ready) begin
      rd_state_d = RD_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
    end
  end

endmodule

/* axil_xbar.sv */
// Top level of the AXI4-Lite crossbar, connects NumMgr manager ports to NumSub subordinate ports
`timescale 1ns/1ps

module axil_xbar import axil_pkg::*, xbar_pkg::*; #(
  parameter int unsigned NumMgr   = 2,
  parameter int unsigned NumSub   = 3,
  parameter int unsigned NumRules = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  axil_req_t  [NumMgr-1:0]    mgr_reqs_i,
  output axil_resp_t [NumMgr-1:0]    mgr_resps_o,
  output axil_req_t  [NumSub-1:0]    sub_reqs_o,
  input  axil_resp_t [NumSub-1:0]    sub_resps_i,
  input  addr_rule_t [NumRules-1:0]  addr_map_i
);

  // Demux side, the extra entry NumSub feeds the error responder
  axil_req_t  [NumMgr-1:0][NumSub:0]   demux_reqs;
  axil_resp_t [NumMgr-1:0][NumSub:0]   demux_resps;
  axil_req_t  [NumSub-1:0][NumMgr-1:0] mux_reqs;
  axil_resp_t [NumSub-1:0][NumMgr-1:0] mux_resps;

  for (genvar i = 0; i < NumMgr; i++) begin : gen_mgr_port
    idx_t aw_idx, ar_idx, aw_sel, ar_sel;
    logic aw_err, ar_err;

    axil_addr_decode #(.NumSub(NumSub), .NumRules(NumRules)) i_aw_decode (
      .addr_i      (mgr_reqs_i[i].aw.addr),
      .addr_map_i  (addr_map_i),
      .idx_o       (aw_idx),
      .dec_error_o (aw_err)
    );

    axil_addr_decode #(.NumSub(NumSub), .NumRules(NumRules)) i_ar_decode (
      .addr_i      (mgr_reqs_i[i].ar.addr),
      .addr_map_i  (addr_map_i),
      .idx_o       (ar_idx),
      .dec_error_o (ar_err)
    );

    assign aw_sel = aw_err ? err_select(NumSub) : aw_idx;
    assign ar_sel = ar_err ? err_select(NumSub) : ar_idx;

    axil_demux #(.NumSub(NumSub), .MaxTrans(MaxTrans)) i_demux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (mgr_reqs_i[i]),
      .aw_select_i (aw_sel),
      .ar_select_i (ar_sel),
      .resp_o      (mgr_resps_o[i]),
      .reqs_o      (demux_reqs[i]),
      .resps_i     (demux_resps[i])
    );

    axil_err_slv i_err_slv (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (demux_reqs[i][NumSub]),
      .resp_o  (demux_resps[i][NumSub])
    );

    for (genvar j = 0; j < NumSub; j++) begin : gen_cross
      assign mux_reqs[j][i]    = demux_reqs[i][j];
      assign demux_resps[i][j] = mux_resps[j][i];
    end
  end

  for (genvar j = 0; j < NumSub; j++) begin : gen_sub_port
    axil_mux #(.NumMgr(NumMgr), .MaxTrans(MaxTrans)) i_mux (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .reqs_i  (mux_reqs[j]),
      .resps_o (mux_resps[j]),
      .req_o   (sub_reqs_o[j]),
      .resp_i  (sub_resps_i[j])
    );
  end

endmodule

/* tb_axil_xbar.sv */
// Self-checking testbench that runs random manager traffic through the crossbar into memory models
`timescale 1ns/1ps

module tb_axil_xbar import axil_pkg::*, xbar_pkg::*; ();

  localparam int unsigned NumMgr   = 2;
  localparam int unsigned NumSub   = 3;
  localparam int unsigned NumRules = 3;
  localparam int unsigned NumTrans = 400;
  localparam int unsigned Timeout  = 2000;

  logic                         clk_i;
  logic                         rst_n_i;
  axil_req_t  [NumMgr-1:0]      mgr_reqs;
  axil_resp_t [NumMgr-1:0]      mgr_resps;
  axil_req_t  [NumSub-1:0]      sub_reqs;
  axil_resp_t [NumSub-1:0]      sub_resps;
  addr_rule_t [NumRules-1:0]    addr_map;

  axil_xbar axil_xbar_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mgr_reqs_i  (mgr_reqs),
    .mgr_resps_o (mgr_resps),
    .sub_reqs_o  (sub_reqs),
    .sub_resps_i (sub_resps),
    .addr_map_i  (addr_map)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Something failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", Timeout, what);
    $display("Something failed");
    $fatal(1, "stopping at first error");
  endtask

  // Manager m owns the odd or even words of every 4 KiB window
  function automatic logic [31:0] word_addr(input int unsigned region, input int unsigned slot,
                                            input int unsigned m);
    return (32'(region) << 12) | (((32'(slot) << 1) | 32'(m)) << 2);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5EED_C0DE;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
                                              input logic [31:0] new_data,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_data;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_window(input int unsigned j, input logic [31:0] addr);
    logic in_win;
    in_win = (addr >= 32'(j) * 32'h1000) && (addr < 32'(j + 1) * 32'h1000);
    check_value($sformatf("sub%0d_addr_in_window", j), 32'(in_win), 32'd1);
  endtask

  // Nothing may be valid on either side while or right after reset
  task automatic check_idle();
    for (int unsigned j = 0; j < NumSub; j++) begin
      check_value($sformatf("sub%0d_aw_valid", j), 32'(sub_reqs[j].aw_valid), 32'd0);
      check_value($sformatf("sub%0d_w_valid", j), 32'(sub_reqs[j].w_valid), 32'd0);
      check_value($sformatf("sub%0d_ar_valid", j), 32'(sub_reqs[j].ar_valid), 32'd0);
    end
    for (int unsigned m = 0; m < NumMgr; m++) begin
      check_value($sformatf("mgr%0d_b_valid", m), 32'(mgr_resps[m].b_valid), 32'd0);
      check_value($sformatf("mgr%0d_r_valid", m), 32'(mgr_resps[m].r_valid), 32'd0);
    end
  endtask

  task automatic write_txn(input int unsigned m, input logic [31:0] addr, input w_chan_t w,
                           output b_chan_t b);
    logic        b_done;
    int unsigned cycles;
    b_done = 1'b0;
    cycles = 0;
    @(posedge clk_i);
    mgr_reqs[m].aw_valid <= 1'b1;
    mgr_reqs[m].aw.addr  <= addr;
    mgr_reqs[m].aw.prot  <= 3'b000;
    mgr_reqs[m].w_valid  <= 1'b1;
    mgr_reqs[m].w        <= w;
    while (!b_done) begin
      @(posedge clk_i);
      if (mgr_reqs[m].aw_valid && mgr_resps[m].aw_ready) mgr_reqs[m].aw_valid <= 1'b0;
      if (mgr_reqs[m].w_valid && mgr_resps[m].w_ready) mgr_reqs[m].w_valid <= 1'b0;
      mgr_reqs[m].b_ready <= (($urandom % 3) != 0); // Random back-pressure
      if (mgr_resps[m].b_valid && mgr_reqs[m].b_ready) begin
        b_done = 1'b1;
        b      = mgr_resps[m].b;
        mgr_reqs[m].b_ready <= 1'b0;
      end
      cycles++;
      if (cycles >= Timeout) report_timeout($sformatf("write response on manager %0d", m));
    end
  endtask

  task automatic read_txn(input int unsigned m, input logic [31:0] addr, output r_chan_t r);
    logic        r_done;
    int unsigned cycles;
    r_done = 1'b0;
    cycles = 0;
    @(posedge clk_i);
    mgr_reqs[m].ar_valid <= 1'b1;
    mgr_reqs[m].ar.addr  <= addr;
    mgr_reqs[m].ar.prot  <= 3'b000;
    while (!r_done) begin
      @(posedge clk_i);
      if (mgr_reqs[m].ar_valid && mgr_resps[m].ar_ready) mgr_reqs[m].ar_valid <= 1'b0;
      mgr_reqs[m].r_ready <= (($urandom % 3) != 0);
      if (mgr_resps[m].r_valid && mgr_reqs[m].r_ready) begin
        r_done = 1'b1;
        r      = mgr_resps[m].r;
        mgr_reqs[m].r_ready <= 1'b0;
      end
      cycles++;
      if (cycles >= Timeout) report_timeout($sformatf("read data on manager %0d", m));
    end
  endtask

  task automatic run_manager(input int unsigned m);
    logic [31:0] ref_mem [3][16]; // Only the words this manager owns
    logic [31:0] addr;
    int unsigned region, slot;
    w_chan_t     w;
    b_chan_t     b;
    r_chan_t     r;
    for (int unsigned rg = 0; rg < 3; rg++) begin
      for (int unsigned s = 0; s < 16; s++) ref_mem[rg][s] = fill_word(word_addr(rg, s, m));
    end
    for (int unsigned t = 0; t < NumTrans; t++) begin
      region = $urandom % 4; // Region 3 is unmapped
      slot   = $urandom % 16;
      addr   = word_addr(region, slot, m);
      if (($urandom % 2) != 0) begin
        w.data = $urandom;
        w.strb = 4'($urandom);
        write_txn(m, addr, w, b);
        if (region < 3) begin
          check_value($sformatf("mgr%0d_b_resp", m), 32'(b.resp), 32'(OKAY));
          ref_mem[region][slot] = merge_bytes(ref_mem[region][slot], w.data, w.strb);
        end else begin
          check_value($sformatf("mgr%0d_b_resp", m), 32'(b.resp), 32'(DECERR));
        end
      end else begin
        read_txn(m, addr, r);
        if (region < 3) begin
          check_value($sformatf("mgr%0d_r_resp", m), 32'(r.resp), 32'(OKAY));
          check_value($sformatf("mgr%0d_r_data", m), r.data, ref_mem[region][slot]);
        end else begin
          check_value($sformatf("mgr%0d_r_resp", m), 32'(r.resp), 32'(DECERR));
          check_value($sformatf("mgr%0d_r_data", m), r.data, 32'd0);
        end
      end
    end
  endtask

  // Subordinate memory models keep one write and one read in flight each
  for (genvar j = 0; j < NumSub; j++) begin : gen_sub
    axil_resp_t  rsp = '0;
    logic [31:0] mem [1024];
    logic [31:0] aw_addr, ar_addr;
    w_chan_t     w_q;
    logic        have_aw, have_w, b_pend, have_ar;
    int unsigned b_wait, r_wait;

    assign sub_resps[j] = rsp;

    always @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rsp     <= '0;
        have_aw = 1'b0;
        have_w  = 1'b0;
        b_pend  = 1'b0;
        have_ar = 1'b0;
        b_wait  = 0;
        r_wait  = 0;
        aw_addr = '0;
        ar_addr = '0;
        for (int unsigned a = 0; a < 1024; a++) begin
          mem[a] = fill_word(32'(j) * 32'h1000 + 32'(a) * 4);
        end
      end else begin
        // B leaves first and frees the write slot
        if (rsp.b_valid && sub_reqs[j].b_ready) begin
          b_pend  = 1'b0;
          have_aw = 1'b0;
          have_w  = 1'b0;
        end else if (b_pend && b_wait > 0) begin
          b_wait--;
        end
        if (sub_reqs[j].aw_valid && rsp.aw_ready) begin
          check_window(j, sub_reqs[j].aw.addr);
          aw_addr = sub_reqs[j].aw.addr;
          have_aw = 1'b1;
        end
        if (sub_reqs[j].w_valid && rsp.w_ready) begin
          w_q    = sub_reqs[j].w;
          have_w = 1'b1;
        end
        if (have_aw && have_w && !b_pend) begin
          mem[aw_addr[11:2]] = merge_bytes(mem[aw_addr[11:2]], w_q.data, w_q.strb);
          b_pend = 1'b1;
          b_wait = $urandom % 4;
        end

        if (rsp.r_valid && sub_reqs[j].r_ready) begin
          have_ar = 1'b0;
        end else if (have_ar && r_wait > 0) begin
          r_wait--;
        end
        if (sub_reqs[j].ar_valid && rsp.ar_ready) begin
          check_window(j, sub_reqs[j].ar.addr);
          ar_addr = sub_reqs[j].ar.addr;
          have_ar = 1'b1;
          r_wait  = $urandom % 4;
        end

        rsp.aw_ready <= !have_aw && (($urandom % 2) != 0);
        rsp.w_ready  <= !have_w && (($urandom % 2) != 0);
        rsp.b_valid  <= b_pend && (b_wait == 0);
        rsp.b.resp   <= OKAY;
        rsp.ar_ready <= !have_ar && (($urandom % 2) != 0);
        rsp.r_valid  <= have_ar && (r_wait == 0);
        rsp.r.data   <= mem[ar_addr[11:2]];
        rsp.r.resp   <= OKAY;
      end
    end
  end

  initial begin
    void'($urandom(5));
    rst_n_i  = 1'b0;
    mgr_reqs = '0;
    for (int unsigned r = 0; r < NumRules; r++) begin
      addr_map[r].idx        = idx_t'(r);
      addr_map[r].start_addr = 32'(r) * 32'h1000;
      addr_map[r].end_addr   = 32'(r + 1) * 32'h1000;
    end

    // First edge under reset loads the flops
    @(posedge clk_i);
    for (int c = 1; c < 4; c++) begin
      @(posedge clk_i);
      check_idle();
    end
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_idle();

    fork
      run_manager(0);
      run_manager(1);
    join

    $display("Everything OK");
    $finish;
  end

endmodule

/* axil_xbar.f */
axil_pkg.sv
xbar_pkg.sv
axil_addr_decode.sv
axil_demux.sv
axil_mux.sv
axil_err_slv.sv
axil_xbar.sv
tb_axil_xbar.sv
